// File: fetch.sv
`timescale 1ns/1ps

module fetch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pc_control,
  input  logic                  stall,
  input  logic                  halt,
  input  logic                  unhalt,
  input  logic                  cache_stall,
  input  vcore_pkg::pc_t        pc_branch,
  input  vcore_pkg::line_t      icache_out,
  output vcore_pkg::pc_t        pc_next,
  output logic                  is_running,
  output vcore_pkg::fetch_out_t fo
);

  import vcore_pkg::*;

  pc_t     pc;
  pc_t     pc_plus_4;
  pc_t     pc_target;
  logic    halt_q;
  logic    halt_d;
  logic    hold;
  instr_t  instr;
  opcode_e opcode;
  // vector ops take their first source from bits 9:5
  logic    vread1_lo;
  logic    li;

  // any of these freezes the pc
  assign hold = stall | cache_stall | halt_q;

  assign pc_plus_4 = pc + PC_W'(4);
  // branch redirect wins over sequential fetch
  assign pc_target = pc_control ? pc_branch : pc_plus_4;
  // icache looks up this address at the same edge that loads the pc
  assign pc_next = hold ? pc : pc_target;

  // unhalt clears and halt sets the flop for the next cycle
  assign halt_d = halt_q ? ~unhalt : halt;
  assign is_running = ~halt_q;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc     <= '0;
      // core comes out of reset halted
      halt_q <= 1'b1;
    end else begin
      pc     <= pc_next;
      halt_q <= halt_d;
    end
  end

  // pick the word addressed by pc bits 3:2
  always_comb begin
    case (pc[3:2])
      2'b00:   instr = icache_out[0*INSTR_W +: INSTR_W];
      2'b01:   instr = icache_out[1*INSTR_W +: INSTR_W];
      2'b10:   instr = icache_out[2*INSTR_W +: INSTR_W];
      default: instr = icache_out[3*INSTR_W +: INSTR_W];
    endcase
  end

  assign opcode = opcode_e'(instr[INSTR_W-1 -: OPCODE_W]);

  // pre-decode of li and the read address select
  always_comb begin
    vread1_lo = 1'b0;
    li        = 1'b0;
    case (opcode)
      vdota, vsma, vcomp, vstr: vread1_lo = 1'b1;
      li_lo, li_hi:             li = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    fo.valid  = ~hold;
    fo.pc     = pc;
    fo.instr  = instr;
    fo.li     = li;
    fo.vread1 = vread1_lo ? instr[9:5] : instr[19:15];
    // second source is always bits 14:10
    fo.vread2 = instr[14:10];
  end

endmodule

// File: front_end.f
vcore_pkg.sv
fetch.sv
icache.sv
vreg_file.sv
front_end.sv
tb_clk_gen.sv
tb_front_end.sv

// File: front_end.sv
`timescale 1ns/1ps

module front_end #(
  parameter int ICACHE_LINES = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pc_control,
  input  logic                  stall,
  input  logic                  halt,
  input  logic                  unhalt,
  input  vcore_pkg::pc_t        pc_branch,
  output vcore_pkg::mem_req_t   mem,
  input  logic                  mem_valid,
  input  vcore_pkg::line_t      mem_line,
  input  logic                  wr_en,
  input  vcore_pkg::vreg_addr_t wr_addr,
  input  vcore_pkg::vreg_t      wr_data,
  output logic                  is_running,
  output vcore_pkg::fetch_out_t fo,
  output vcore_pkg::vread_t     rd
);

  import vcore_pkg::*;

  // fetch to icache
  pc_t   pc_next;
  // icache to fetch
  line_t icache_out;
  logic  cache_stall;

  fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .pc_control  (pc_control),
    .stall       (stall),
    .halt        (halt),
    .unhalt      (unhalt),
    .cache_stall (cache_stall),
    .pc_branch   (pc_branch),
    .icache_out  (icache_out),
    .pc_next     (pc_next),
    .is_running  (is_running),
    .fo          (fo)
  );

  icache #(
    .ICACHE_LINES (ICACHE_LINES)
  ) u_icache (
    .clk         (clk),
    .rst         (rst),
    .pc_next     (pc_next),
    .icache_out  (icache_out),
    .cache_stall (cache_stall),
    .mem         (mem),
    .mem_valid   (mem_valid),
    .mem_line    (mem_line)
  );

  // read addresses come straight from the pre-decode
  vreg_file u_vreg_file (
    .clk     (clk),
    .rst     (rst),
    .vread1  (fo.vread1),
    .vread2  (fo.vread2),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd      (rd)
  );

endmodule

// File: front_end_trace.txt
# M line_addr data128 (word 0 in low bits) | W reg data128 | C code target
# codes N none, U unhalt, H halt, S stall, B branch; W and B repeat until valid
M 00000000 12019000_5a001060_48001060_10019000
M 00000001 48001060_7f019000_24001060_6c001060
M 00000010 240018a0_6c0018a0_5a0018a0_10031800
C N 0
C N 0
C U 0
W 03 0123456789abcdef0011223344556677
C N 0
C N 0
C N 0
C S 0
C S 0
C N 0
C N 0
W 04 fedcba98765432100f0e0d0c0b0a0908
B 100
C N 0
C N 0
C N 0
C N 0
C N 0
C H 0
C N 0
C N 0
C U 0
C N 0
C N 0
B 010
C N 0
C N 0
C N 0
W 05 a5a5a5a55a5a5a5a0123012301230123
C N 0

// File: icache.sv
`timescale 1ns/1ps

module icache #(
  parameter int ICACHE_LINES = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  vcore_pkg::pc_t      pc_next,
  output vcore_pkg::line_t    icache_out,
  output logic                cache_stall,
  output vcore_pkg::mem_req_t mem,
  input  logic                mem_valid,
  input  vcore_pkg::line_t    mem_line
);

  import vcore_pkg::*;

  // line address splits into tag and index
  localparam int INDEX_W = $clog2(ICACHE_LINES);
  localparam int TAG_W   = LINE_ADDR_W - INDEX_W;

  // storage arrays
  logic [TAG_W-1:0]        tag_mem  [ICACHE_LINES];
  line_t                   data_mem [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] line_vld;

  fill_state_e            state;
  fill_state_e            state_nxt;
  // lookup address that tracks the fetch pc
  pc_t                    addr_q;
  pc_t                    addr_d;
  logic [LINE_ADDR_W-1:0] line_addr_q;
  logic [INDEX_W-1:0]     idx_q;
  logic [INDEX_W-1:0]     idx_d;
  logic [TAG_W-1:0]       tag_q;
  logic                   hit;
  line_t                  line_q;

  assign line_addr_q = addr_q[PC_W-1:LINE_OFS_W];
  assign idx_q       = line_addr_q[INDEX_W-1:0];
  assign tag_q       = line_addr_q[LINE_ADDR_W-1:INDEX_W];

  // tag compare against the registered lookup
  assign hit = line_vld[idx_q] && (tag_mem[idx_q] == tag_q);

  // on a miss or during a fill keep the address so the stalled pc is refetched
  assign addr_d = (state == idle && hit) ? pc_next : addr_q;
  assign idx_d  = addr_d[LINE_OFS_W +: INDEX_W];

  always_comb begin
    state_nxt = state;
    case (state)
      // request goes out the cycle after the miss shows up
      idle: begin
        if (!hit) begin
          state_nxt = fill;
        end
      end
      // wait for the memory response pulse
      fill: begin
        if (mem_valid) begin
          state_nxt = refill;
        end
      end
      // one cycle to read the freshly written line
      refill:  state_nxt = idle;
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state    <= idle;
      addr_q   <= '0;
      line_vld <= '0;
    end else begin
      state  <= state_nxt;
      addr_q <= addr_d;
      if (state == fill && mem_valid) begin
        line_vld[idx_q] <= 1'b1;
      end
    end
  end

  // line fill and registered line read
  always_ff @(posedge clk) begin
    if (state == fill && mem_valid) begin
      data_mem[idx_q] <= mem_line;
      tag_mem[idx_q]  <= tag_q;
    end
    // the fill edge still reads old data so refill picks up the new line
    line_q <= data_mem[idx_d];
  end

  assign icache_out = line_q;

  // stall until the line is present and read out
  assign cache_stall = (state != idle) || !hit;

  // request level stays up through the whole fill
  assign mem.req       = (state == fill);
  assign mem.line_addr = line_addr_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the front end testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_front_end \
  -f front_end.f -o tb_front_end > build.log 2>&1 \
  && ./obj_dir/tb_front_end > sim.log 2>&1 \
  || echo "build or run failed, see build.log and sim.log"

grep -qx "all tests passed" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset drops on a falling edge away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: tb_front_end.sv
`timescale 1ns/1ps

module tb_front_end;

  import vcore_pkg::*;

  logic       clk;
  logic       rst;
  logic       pc_control;
  logic       stall;
  logic       halt;
  logic       unhalt;
  pc_t        pc_branch;
  mem_req_t   mem;
  logic       mem_valid;
  line_t      mem_line;
  logic       wr_en;
  vreg_addr_t wr_addr;
  vreg_t      wr_data;
  logic       is_running;
  fetch_out_t fo;
  vread_t     rd;

  // memory image from the trace keyed by line address
  line_t       img [logic [31:0]];
  // control script with one entry per step
  string       step_kind [$];
  pc_t         step_a [$];
  vreg_t       step_d [$];
  logic        loaded;
  // reference model state
  pc_t         exp_pc;
  logic        exp_running;
  vreg_t       shadow [NUM_VREGS];
  logic        rd_pending;
  vread_t      rd_exp;
  // memory model state
  logic [31:0] lfsr;
  logic        busy;
  logic [31:0] req_addr;
  int          cnt;
  int          fetch_errs;
  int          vread_errs;
  int          flag_errs;
  int          other_errs;

  tb_clk_gen #(.PERIOD(8), .RST_CYCLES(3)) u_clk_gen (.clk(clk), .rst(rst));

  front_end #(.ICACHE_LINES(16)) DUT (
    .clk        (clk),
    .rst        (rst),
    .pc_control (pc_control),
    .stall      (stall),
    .halt       (halt),
    .unhalt     (unhalt),
    .pc_branch  (pc_branch),
    .mem        (mem),
    .mem_valid  (mem_valid),
    .mem_line   (mem_line),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .is_running (is_running),
    .fo         (fo),
    .rd         (rd)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // lines not in the trace get a pattern built from the whole line address
  function automatic line_t line_image(input logic [31:0] la);
    line_t l;
    if (img.exists(la)) begin
      return img[la];
    end
    for (int k = 0; k < 4; k++) begin
      l[k*32 +: 32] = {la[29:0], 2'(k)} ^ {la[31:30], 30'h1e3779b9};
    end
    return l;
  endfunction

  function automatic instr_t image_word(input pc_t pc);
    line_t l;
    l = line_image(pc[35:4]);
    return l[{pc[3:2], 5'b00000} +: 32];
  endfunction

  task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
    if (got.pc !== exp.pc) begin
      $display("FAIL fo.pc got %h exp %h", got.pc, exp.pc);
      fetch_errs++;
    end
    if (got.instr !== exp.instr) begin
      $display("FAIL fo.instr got %h exp %h at pc %h", got.instr, exp.instr, exp.pc);
      fetch_errs++;
    end
    if (got.li !== exp.li) begin
      $display("FAIL fo.li got %h exp %h at pc %h", got.li, exp.li, exp.pc);
      fetch_errs++;
    end
    if (got.vread1 !== exp.vread1 || got.vread2 !== exp.vread2) begin
      $display("FAIL fo.vread1/vread2 got %h/%h exp %h/%h at pc %h",
               got.vread1, got.vread2, exp.vread1, exp.vread2, exp.pc);
      fetch_errs++;
    end
  endtask

  task automatic check_vread(input vread_t got, input vread_t exp);
    if (got.rdata1 !== exp.rdata1) begin
      $display("FAIL rd.rdata1 got %h exp %h", got.rdata1, exp.rdata1);
      vread_errs++;
    end
    if (got.rdata2 !== exp.rdata2) begin
      $display("FAIL rd.rdata2 got %h exp %h", got.rdata2, exp.rdata2);
      vread_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h exp %h", name, got, exp);
      flag_errs++;
    end
  endtask

  task automatic check_mem(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("FAIL mem got req %h line_addr %h exp req %h line_addr %h",
               got.req, got.line_addr, exp.req, exp.line_addr);
      flag_errs++;
    end
  endtask

  // trace lines are M addr data, W reg data, C code target or B target
  task automatic load_trace();
    int    fd;
    int    rc;
    string line;
    string tag;
    string code;
    logic [31:0] la;
    line_t ld;
    pc_t   a;
    vreg_t d;
    fd = $fopen("front_end_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file front_end_trace.txt");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      tag  = "";
      rc = $fgets(line, fd);
      rc = $sscanf(line, "%s", tag);
      if (tag == "M") begin
        rc = $sscanf(line, "%s %h %h", tag, la, ld);
        img[la] = ld;
      end else if (tag == "W") begin
        rc = $sscanf(line, "%s %h %h", tag, a, d);
        step_kind.push_back("W");
        step_a.push_back(a);
        step_d.push_back(d);
      end else if (tag == "C") begin
        rc = $sscanf(line, "%s %s %h", tag, code, a);
        step_kind.push_back(code);
        step_a.push_back(a);
        step_d.push_back('0);
      end else if (tag == "B") begin
        // branch step written without the C prefix
        rc = $sscanf(line, "%s %h", tag, a);
        step_kind.push_back("B");
        step_a.push_back(a);
        step_d.push_back('0);
      end
    end
    $fclose(fd);
  endtask

  // all strobes default low each cycle
  task automatic drive_step(input string kind, input pc_t a, input vreg_t d);
    pc_control = 1'b0;
    stall      = 1'b0;
    halt       = 1'b0;
    unhalt     = 1'b0;
    wr_en      = 1'b0;
    pc_branch  = '0;
    wr_addr    = '0;
    wr_data    = '0;
    if (kind == "U") begin
      unhalt = 1'b1;
    end else if (kind == "H") begin
      halt = 1'b1;
    end else if (kind == "S") begin
      stall = 1'b1;
    end else if (kind == "B") begin
      pc_control = 1'b1;
      pc_branch  = a;
    end else if (kind == "W") begin
      wr_en   = 1'b1;
      wr_addr = a[4:0];
      wr_data = d;
    end
  endtask

  // compare one cycle against the model just before the rising edge
  task automatic sample_cycle(output logic seen);
    fetch_out_t exp;
    instr_t     w;
    opcode_e    op;
    seen = fo.valid;
    check_flag("is_running", is_running, exp_running);
    if (rd_pending) begin
      check_vread(rd, rd_exp);
      rd_pending = 1'b0;
    end
    // nothing may be delivered under stall or halt
    if (stall || !exp_running) begin
      check_flag("fo.valid", fo.valid, 1'b0);
    end
    if (fo.valid === 1'b1) begin
      w  = image_word(exp_pc);
      op = opcode_e'(w[31:25]);
      exp.pc     = exp_pc;
      exp.instr  = w;
      exp.li     = (op == li_lo) || (op == li_hi);
      exp.vread1 = (op == vdota || op == vsma || op == vcomp || op == vstr) ?
                   w[9:5] : w[19:15];
      exp.vread2 = w[14:10];
      check_fetch(fo, exp);
      // same cycle write wins over the stored value
      rd_exp.rdata1 = (wr_en && wr_addr == exp.vread1) ? wr_data : shadow[exp.vread1];
      rd_exp.rdata2 = (wr_en && wr_addr == exp.vread2) ? wr_data : shadow[exp.vread2];
      rd_pending = 1'b1;
      exp_pc = pc_control ? pc_branch : exp_pc + 36'd4;
    end
    if (wr_en) begin
      shadow[wr_addr] = wr_data;
    end
    if (exp_running && halt) begin
      exp_running = 1'b0;
    end else if (!exp_running && unhalt) begin
      exp_running = 1'b1;
    end
  endtask

  // memory model answers a request after 1 to 4 cycles
  always @(negedge clk) begin
    if (!rst) begin
      if (mem_valid) begin
        mem_valid = 1'b0;
        busy      = 1'b0;
      end else if (busy) begin
        // request must hold steady until answered
        check_mem(mem, {1'b1, req_addr});
        cnt = cnt - 1;
        if (cnt == 0) begin
          mem_valid = 1'b1;
          mem_line  = line_image(req_addr);
        end
      end else if (mem.req) begin
        busy     = 1'b1;
        // a miss is always for the line of the held pc
        req_addr = exp_pc[35:4];
        check_mem(mem, {1'b1, req_addr});
        lfsr     = lfsr_next(lfsr);
        cnt      = 1 + int'(lfsr[0]);
        lfsr     = lfsr_next(lfsr);
        cnt      = cnt + 2 * int'(lfsr[0]);
      end
    end
  end

  initial begin : main
    logic seen;
    string kind;
    pc_control  = 1'b0;
    stall       = 1'b0;
    halt        = 1'b0;
    unhalt      = 1'b0;
    pc_branch   = '0;
    mem_valid   = 1'b0;
    mem_line    = '0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    lfsr        = 32'h6a00907c;
    busy        = 1'b0;
    req_addr    = '0;
    cnt         = 0;
    exp_pc      = '0;
    exp_running = 1'b0;
    rd_pending  = 1'b0;
    rd_exp      = '0;
    fetch_errs  = 0;
    vread_errs  = 0;
    flag_errs   = 0;
    other_errs  = 0;
    loaded      = 1'b0;
    for (int r = 0; r < NUM_VREGS; r++) begin
      shadow[r] = '0;
    end
    load_trace();
    loaded = 1'b1;
    // state right out of reset
    @(negedge rst);
    #1;
    check_flag("is_running", is_running, 1'b0);
    check_flag("fo.valid", fo.valid, 1'b0);
    check_mem(mem, '0);
    check_vread(rd, '0);
    // branch and write steps repeat until an instruction is delivered
    for (int i = 0; i < step_kind.size(); i++) begin
      kind = step_kind[i];
      do begin
        @(negedge clk);
        drive_step(kind, step_a[i], step_d[i]);
        #3;
        sample_cycle(seen);
      end while ((kind == "B" || kind == "W") && seen !== 1'b1);
    end
    // one more cycle for the last register read
    @(negedge clk);
    drive_step("N", '0, '0);
    #3;
    sample_cycle(seen);
    $display("errors fetch %0d vread %0d flag %0d other %0d",
             fetch_errs, vread_errs, flag_errs, other_errs);
    if (fetch_errs + vread_errs + flag_errs + other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog allows 40 cycles per trace step
  initial begin : watchdog
    wait (loaded);
    repeat ((step_kind.size() + 2) * 40) @(posedge clk);
    $display("watchdog expired, the run did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

// File: vcore_pkg.sv
package vcore_pkg;

  // basic widths of the front end
  localparam int PC_W        = 36;
  localparam int INSTR_W     = 32;
  localparam int LINE_W      = 128;
  localparam int LINE_OFS_W  = 4;
  localparam int LINE_ADDR_W = PC_W - LINE_OFS_W;
  localparam int VREG_ADDR_W = 5;
  localparam int VREG_W      = 128;
  localparam int NUM_VREGS   = 32;
  localparam int OPCODE_W    = 7;

  // program counter that doubles as byte address into the cache
  typedef logic [PC_W-1:0] pc_t;
  typedef logic [INSTR_W-1:0] instr_t;
  // four instruction words, word 0 in the low bits
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [VREG_ADDR_W-1:0] vreg_addr_t;
  typedef logic [VREG_W-1:0] vreg_t;

  // opcodes found in instr bits 31:25
  typedef enum logic [OPCODE_W-1:0] {
    li_lo = 7'b0001000,
    li_hi = 7'b0001001,
    vstr  = 7'b0010010,
    vdota = 7'b0100100,
    vsma  = 7'b0101101,
    vcomp = 7'b0110110
  } opcode_e;

  // icache line fill states
  typedef enum logic [1:0] {
    idle,
    fill,
    refill
  } fill_state_e;

  // per-cycle fetch result
  typedef struct packed {
    logic       valid;
    pc_t        pc;
    instr_t     instr;
    logic       li;
    vreg_addr_t vread1;
    vreg_addr_t vread2;
  } fetch_out_t;

  // registered register file read data
  typedef struct packed {
    vreg_t rdata1;
    vreg_t rdata2;
  } vread_t;

  // line request towards external memory where req is a level
  typedef struct packed {
    logic                   req;
    logic [LINE_ADDR_W-1:0] line_addr;
  } mem_req_t;

endpackage

// File: vreg_file.sv
`timescale 1ns/1ps

module vreg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  vcore_pkg::vreg_addr_t vread1,
  input  vcore_pkg::vreg_addr_t vread2,
  input  logic                  wr_en,
  input  vcore_pkg::vreg_addr_t wr_addr,
  input  vcore_pkg::vreg_t      wr_data,
  output vcore_pkg::vread_t     rd
);

  import vcore_pkg::*;

  // register array
  vreg_t  regs [NUM_VREGS];
  vread_t rd_d;

  // write-first bypass lets a same-cycle write show up on the read
  always_comb begin
    if (wr_en && (wr_addr == vread1)) begin
      rd_d.rdata1 = wr_data;
    end else begin
      rd_d.rdata1 = regs[vread1];
    end
    if (wr_en && (wr_addr == vread2)) begin
      rd_d.rdata2 = wr_data;
    end else begin
      rd_d.rdata2 = regs[vread2];
    end
  end

  // all registers start out zero
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_VREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // read data lands one cycle after the addresses
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd <= '0;
    end else begin
      rd <= rd_d;
    end
  end

endmodule
